/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data and address width
`define XLEN 32

// Register index width, x0 to x31
`define REG_AW 5

// Data memory depth in words, addresses wrap modulo the depth
`define DMEM_WORDS 256

// Program counter after reset
`define RESET_PC 32'h0000_0000

`endif

/* source/isaPkg.sv */
package isaPkg;

    // RV32I major opcodes in the supported subset
    typedef enum logic [6:0] {
        opcReg    = 7'b0110011,
        opcImm    = 7'b0010011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5
    } aluOpT;

    // Decoded instruction, illegal encodings map to insNop
    typedef enum logic [3:0] {
        insNop  = 4'd0,
        insAdd  = 4'd1,
        insSub  = 4'd2,
        insAnd  = 4'd3,
        insOr   = 4'd4,
        insXor  = 4'd5,
        insSlt  = 4'd6,
        insAddi = 4'd7,
        insLw   = 4'd8,
        insSw   = 4'd9,
        insBeq  = 4'd10,
        insBne  = 4'd11
    } instrOpT;

endpackage

/* source/pipePkg.sv */
`include "core_consts.svh"

package pipePkg;

    import isaPkg::*;

    // Contents of the decode-to-execute register
    typedef struct packed {
        logic                valid;
        instrOpT             op;
        aluOpT               aluOp;
        logic                useImm;
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic [`REG_AW-1:0]  rs1;
        logic [`REG_AW-1:0]  rs2;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    rs1Val;
        logic [`XLEN-1:0]    rs2Val;
        logic [`XLEN-1:0]    imm;
        logic [`XLEN-1:0]    pc;
    } decExeT;

    typedef struct packed {
        logic                valid;
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    aluResult;
        logic [`XLEN-1:0]    storeData;
        logic [`XLEN-1:0]    pc;
    } exeResT;

    // One register write as seen on the retire port
    typedef struct packed {
        logic                valid;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    data;
        logic [`XLEN-1:0]    pc;
    } retireT;

    typedef struct packed {
        logic                taken;
        logic [`XLEN-1:0]    target;
    } redirectT;

endpackage

/* source/fetchUnit.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module fetchUnit (
    input  logic                clk,
    input  logic                rstN,
    input  pipePkg::redirectT   redirect,
    output logic [`XLEN-1:0]    imemAddr,
    input  logic [`XLEN-1:0]    imemData,
    output logic [`XLEN-1:0]    fetchInstr,
    output logic [`XLEN-1:0]    fetchPc,
    output logic                fetchValid
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] nextPc;

    assign imemAddr = pc;

    // Branch target wins over sequential fetch
    always_comb begin
        if (redirect.taken) begin
            nextPc = redirect.target;
        end else begin
            nextPc = pc + `XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // Word in flight is squashed on redirect
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= !redirect.taken;
        end
    end

    always_ff @(posedge clk) begin
        fetchInstr <= imemData;
        fetchPc    <= pc;
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module regFile (
    input  logic                clk,
    input  logic                rstN,
    input  logic [`REG_AW-1:0]  rs1,
    input  logic [`REG_AW-1:0]  rs2,
    output logic [`XLEN-1:0]    rs1Val,
    output logic [`XLEN-1:0]    rs2Val,
    input  logic                wrEn,
    input  logic [`REG_AW-1:0]  wrAddr,
    input  logic [`XLEN-1:0]    wrData
);

    logic [`XLEN-1:0] regs [2**`REG_AW];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**`REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Same-cycle write passes straight to the reader
    always_comb begin
        if (wrEn && wrAddr != '0 && wrAddr == rs1) begin
            rs1Val = wrData;
        end else begin
            rs1Val = regs[rs1];
        end
        if (wrEn && wrAddr != '0 && wrAddr == rs2) begin
            rs2Val = wrData;
        end else begin
            rs2Val = regs[rs2];
        end
    end

    x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
        (rs1 != '0 || rs1Val == '0) && (rs2 != '0 || rs2Val == '0));

endmodule

/* source/decodeStage.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module decodeStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic [`XLEN-1:0]    fetchInstr,
    input  logic [`XLEN-1:0]    fetchPc,
    input  logic                fetchValid,
    input  pipePkg::redirectT   redirect,
    output logic [`REG_AW-1:0]  rs1,
    output logic [`REG_AW-1:0]  rs2,
    input  logic [`XLEN-1:0]    rs1Val,
    input  logic [`XLEN-1:0]    rs2Val,
    output pipePkg::decExeT     decExe
);

    import isaPkg::*;
    import pipePkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    instrOpT    op;
    decExeT     dec;

    assign funct3 = fetchInstr[14:12];
    assign funct7 = fetchInstr[31:25];
    assign rs1    = fetchInstr[19:15];
    assign rs2    = fetchInstr[24:20];

    always_comb begin
        op = insNop;
        case (fetchInstr[6:0])
            opcReg: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = insAdd;
                        3'b010:  op = insSlt;
                        3'b100:  op = insXor;
                        3'b110:  op = insOr;
                        3'b111:  op = insAnd;
                        default: op = insNop;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = insSub;
                end
            end
            opcImm: begin
                if (funct3 == 3'b000) begin
                    op = insAddi;
                end
            end
            opcLoad: begin
                if (funct3 == 3'b010) begin
                    op = insLw;
                end
            end
            opcStore: begin
                if (funct3 == 3'b010) begin
                    op = insSw;
                end
            end
            opcBranch: begin
                if (funct3 == 3'b000) begin
                    op = insBeq;
                end else if (funct3 == 3'b001) begin
                    op = insBne;
                end
            end
            default: op = insNop;
        endcase
    end

    always_comb begin
        dec          = '0;
        dec.valid    = fetchValid;
        dec.op       = fetchValid ? op : insNop;
        case (dec.op)
            insSub:  dec.aluOp = aluSub;
            insAnd:  dec.aluOp = aluAnd;
            insOr:   dec.aluOp = aluOr;
            insXor:  dec.aluOp = aluXor;
            insSlt:  dec.aluOp = aluSlt;
            default: dec.aluOp = aluAdd;
        endcase
        dec.useImm   = dec.op inside {insAddi, insLw, insSw};
        dec.regWrite = dec.op inside {insAdd, insSub, insAnd, insOr, insXor, insSlt,
                                      insAddi, insLw};
        dec.memRead  = dec.op == insLw;
        dec.memWrite = dec.op == insSw;
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.rd       = fetchInstr[11:7];
        dec.rs1Val   = rs1Val;
        dec.rs2Val   = rs2Val;
        dec.pc       = fetchPc;
        // I, S or B format immediate
        case (fetchInstr[6:0])
            opcStore:  dec.imm = {{20{fetchInstr[31]}}, fetchInstr[31:25], fetchInstr[11:7]};
            opcBranch: dec.imm = {{19{fetchInstr[31]}}, fetchInstr[31], fetchInstr[7],
                                  fetchInstr[30:25], fetchInstr[11:8], 1'b0};
            default:   dec.imm = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decExe <= '0;
        end else if (redirect.taken) begin
            decExe <= '0;
        end else begin
            decExe <= dec;
        end
    end

    // Both younger slots stay empty after a flush
    flushClearsValid: assert property (@(posedge clk) disable iff (!rstN)
        ($past(redirect.taken) || $past(redirect.taken, 2)) |-> !decExe.valid);

endmodule

/* source/executeStage.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module executeStage (
    input  logic                clk,
    input  logic                rstN,
    input  pipePkg::decExeT     decExe,
    input  logic                fwdValid,
    input  logic [`REG_AW-1:0]  fwdRd,
    input  logic [`XLEN-1:0]    fwdData,
    output pipePkg::redirectT   redirect,
    output pipePkg::exeResT     exeRes
);

    import isaPkg::*;

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] rs2Fwd;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluResult;
    logic             equal;

    // Bypass from the instruction one stage ahead
    always_comb begin
        if (fwdValid && fwdRd != '0 && fwdRd == decExe.rs1) begin
            opA = fwdData;
        end else begin
            opA = decExe.rs1Val;
        end
        if (fwdValid && fwdRd != '0 && fwdRd == decExe.rs2) begin
            rs2Fwd = fwdData;
        end else begin
            rs2Fwd = decExe.rs2Val;
        end
    end

    assign opB = decExe.useImm ? decExe.imm : rs2Fwd;

    always_comb begin
        case (decExe.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    assign equal = opA == rs2Fwd;

    always_comb begin
        redirect.taken  = decExe.valid &&
                          ((decExe.op == insBeq && equal) || (decExe.op == insBne && !equal));
        redirect.target = decExe.pc + decExe.imm;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeRes <= '0;
        end else begin
            exeRes.valid     <= decExe.valid;
            exeRes.regWrite  <= decExe.regWrite;
            exeRes.memRead   <= decExe.memRead;
            exeRes.memWrite  <= decExe.memWrite;
            exeRes.rd        <= decExe.rd;
            exeRes.aluResult <= aluResult;
            exeRes.storeData <= rs2Fwd;
            exeRes.pc        <= decExe.pc;
        end
    end

    // Squashed shadow of a taken branch never redirects
    shadowNotTaken: assert property (@(posedge clk) disable iff (!rstN)
        redirect.taken |=> !redirect.taken);

endmodule

/* source/resultStage.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module resultStage (
    input  logic                clk,
    input  logic                rstN,
    input  pipePkg::exeResT     exeRes,
    output logic                wrEn,
    output logic [`REG_AW-1:0]  wrAddr,
    output logic [`XLEN-1:0]    wrData,
    output logic                fwdValid,
    output logic [`REG_AW-1:0]  fwdRd,
    output logic [`XLEN-1:0]    fwdData,
    output pipePkg::retireT     retire
);

    localparam int DmemAw = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]  dmem [`DMEM_WORDS];
    logic [DmemAw-1:0] wordIdx;
    logic [`XLEN-1:0]  loadData;

    // Word address, wraps at the memory depth
    assign wordIdx  = exeRes.aluResult[DmemAw+1:2];
    assign loadData = dmem[wordIdx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (exeRes.valid && exeRes.memWrite) begin
            dmem[wordIdx] <= exeRes.storeData;
        end
    end

    assign wrEn   = exeRes.valid && exeRes.regWrite;
    assign wrAddr = exeRes.rd;
    assign wrData = exeRes.memRead ? loadData : exeRes.aluResult;

    // Final writeback value, load data included
    assign fwdValid = wrEn;
    assign fwdRd    = wrAddr;
    assign fwdData  = wrData;

    always_comb begin
        retire.valid = wrEn && exeRes.rd != '0;
        retire.rd    = exeRes.rd;
        retire.data  = wrData;
        retire.pc    = exeRes.pc;
    end

    noReadAndWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(exeRes.memRead && exeRes.memWrite));

endmodule

/* source/pipelineCore.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module pipelineCore (
    input  logic                clk,
    input  logic                rstN,
    output logic [`XLEN-1:0]    imemAddr,
    input  logic [`XLEN-1:0]    imemData,
    output pipePkg::retireT     retire
);

    import pipePkg::*;

    redirectT           redirect;
    decExeT             decExe;
    exeResT             exeRes;
    logic [`XLEN-1:0]   fetchInstr;
    logic [`XLEN-1:0]   fetchPc;
    logic               fetchValid;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`XLEN-1:0]   rs1Val;
    logic [`XLEN-1:0]   rs2Val;
    logic               wrEn;
    logic [`REG_AW-1:0] wrAddr;
    logic [`XLEN-1:0]   wrData;
    logic               fwdValid;
    logic [`REG_AW-1:0] fwdRd;
    logic [`XLEN-1:0]   fwdData;

    fetchUnit fetch0 (.clk, .rstN, .redirect, .imemAddr, .imemData,
                      .fetchInstr, .fetchPc, .fetchValid);

    regFile regs0 (.clk, .rstN, .rs1, .rs2, .rs1Val, .rs2Val, .wrEn, .wrAddr, .wrData);

    decodeStage decode0 (.clk, .rstN, .fetchInstr, .fetchPc, .fetchValid, .redirect,
                         .rs1, .rs2, .rs1Val, .rs2Val, .decExe);

    executeStage execute0 (.clk, .rstN, .decExe, .fwdValid, .fwdRd, .fwdData,
                           .redirect, .exeRes);

    resultStage result0 (.clk, .rstN, .exeRes, .wrEn, .wrAddr, .wrData,
                         .fwdValid, .fwdRd, .fwdData, .retire);

endmodule

/* dv/coreTb.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module coreTb;

    localparam logic [31:0] Nop      = 32'h0000_0013;
    localparam logic [31:0] SelfLoop = 32'h0000_0063;
    localparam int          DmemAw   = $clog2(`DMEM_WORDS);
    // funct3 of ADD, SUB, AND, OR, XOR, SLT
    localparam logic [2:0]  RegF3 [6] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010};

    logic             clk;
    logic             rstN;
    logic [`XLEN-1:0] imemAddr;
    logic [`XLEN-1:0] imemData;
    pipePkg::retireT  retire;

    logic [31:0]      imem [1024];
    logic [4:0]       expRd [$];
    logic [31:0]      expData [$];
    logic [31:0]      expPc [$];
    logic [31:0]      rngState;
    int               progLen;
    int               seen = 0;
    int               checkErrors = 0;
    int               timeoutErrors = 0;
    string            testName;

    pipelineCore dut0 (.clk, .rstN, .imemAddr, .imemData, .retire);

    assign imemData = imem[imemAddr[11:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    // Opcode 7'h13 gives ADDI and 7'h03 gives LW
    function automatic logic [31:0] encI(input logic [6:0] opc, input int rd, input int rs1,
                                         input int imm);
        return {imm[11:0], rs1[4:0], ((opc == 7'h03) ? 3'b010 : 3'b000), rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encS(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    // Architectural model that runs until the final self-loop
    function automatic void iss();
        logic [31:0] x [32];
        logic [31:0] mem [`DMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic        wr;
        int          steps;
        x = '{default: '0};
        mem = '{default: '0};
        expRd.delete();
        expData.delete();
        expPc.delete();
        pc = `RESET_PC;
        steps = 0;
        while (imem[pc[11:2]] != SelfLoop && steps < 5000) begin
            ins = imem[pc[11:2]];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            nextPc = pc + 32'd4;
            wr = 1'b0;
            res = '0;
            case (ins[6:0])
                7'h33: begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h007: res = a & b;
                        10'h006: res = a | b;
                        10'h004: res = a ^ b;
                        10'h002: res = {31'b0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;
                    endcase
                end
                7'h13: begin
                    wr = ins[14:12] == 3'b000;
                    res = a + {{20{ins[31]}}, ins[31:20]};
                end
                7'h03: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    wr = ins[14:12] == 3'b010;
                    res = mem[addr[DmemAw+1:2]];
                end
                7'h23: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (ins[14:12] == 3'b010) begin
                        mem[addr[DmemAw+1:2]] = b;
                    end
                end
                7'h63: begin
                    if ((ins[14:12] == 3'b000 && a == b) ||
                        (ins[14:12] == 3'b001 && a != b)) begin
                        nextPc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                       ins[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
                expRd.push_back(ins[11:7]);
                expData.push_back(res);
                expPc.push_back(pc);
            end
            pc = nextPc;
            steps++;
        end
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic startProgram();
        @(posedge clk);
        rstN <= 1'b0;
        imem = '{default: Nop};
        progLen = 0;
    endtask

    task automatic runProgram(input string name);
        int cycles;
        // Padding so a forward branch at the end still lands on the loop
        for (int i = 0; i < 3; i++) begin
            emit(SelfLoop);
        end
        testName = name;
        iss();
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        cycles = 0;
        while (seen < expPc.size() && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (seen < expPc.size()) begin
            $display("Retire count stalled at %0d of %0d in %s", seen, expPc.size(), name);
            timeoutErrors++;
        end
        // Drain so extra retirements still get caught
        repeat (10) @(posedge clk);
    endtask

    task automatic buildRandom(input int count);
        logic [31:0] r;
        int          k;
        for (int i = 0; i < count; i++) begin
            rngState = xorshift(rngState);
            r = rngState;
            k = int'(r[31:16]) % 10;
            if (k < 6) begin
                emit(encR((k == 1) ? 7'h20 : 7'h00, RegF3[k], int'(r[2:0]), int'(r[5:3]),
                          int'(r[8:6])));
            end else begin
                case (k)
                    6: emit(encI(7'h13, int'(r[2:0]), int'(r[5:3]), int'(r[20:9])));
                    7: emit(encI(7'h03, int'(r[2:0]), 0, 4 * int'(r[12:9])));
                    8: emit(encS(0, int'(r[8:6]), 4 * int'(r[12:9])));
                    default: emit(encB({2'b00, r[9]}, int'(r[5:3]), int'(r[8:6]),
                                       r[10] ? 12 : 8));
                endcase
            end
        end
    endtask

    // Retire checker
    always @(negedge clk) begin
        if (!rstN) begin
            seen = 0;
            if (imemAddr !== `RESET_PC) begin
                $display("FAILED %s reset pc: expected %h actual %h", testName, `RESET_PC,
                         imemAddr);
                checkErrors++;
            end
            if (retire.valid !== 1'b0) begin
                $display("A retire was reported while reset was held in %s", testName);
                checkErrors++;
            end
        end else if (retire.valid === 1'b1) begin
            if (seen >= expPc.size()) begin
                $display("Unexpected retire in %s from pc %h", testName, retire.pc);
                checkErrors++;
            end else if ({retire.rd, retire.data, retire.pc} !==
                         {expRd[seen], expData[seen], expPc[seen]}) begin
                $write("FAILED %s retire %0d: expected rd %0d data %h pc %h, ",
                       testName, seen, expRd[seen], expData[seen], expPc[seen]);
                $display("actual rd %0d data %h pc %h", retire.rd, retire.data, retire.pc);
                checkErrors++;
            end
            seen++;
        end
    end

    initial begin
        rstN = 1'b0;
        imem = '{default: Nop};
        rngState = 32'd33314;
        testName = "reset";

        // Each result feeds the next
        startProgram();
        emit(encI(7'h13, 1, 0, 5));
        emit(encI(7'h13, 2, 1, -12));
        emit(encR(7'h00, 3'b000, 3, 1, 2));
        emit(encR(7'h20, 3'b000, 4, 3, 1));
        emit(encR(7'h00, 3'b111, 5, 4, 2));
        emit(encR(7'h00, 3'b110, 6, 5, 4));
        emit(encR(7'h00, 3'b100, 7, 6, 3));
        emit(encR(7'h00, 3'b010, 1, 7, 2));
        runProgram("aluChain");

        startProgram();
        emit(encI(7'h13, 1, 0, 100));
        emit(encI(7'h13, 2, 0, -7));
        emit(encS(0, 1, 0));
        emit(encS(0, 2, 4));
        emit(encI(7'h03, 3, 0, 0));
        emit(encR(7'h00, 3'b000, 4, 3, 3));
        emit(encI(7'h03, 5, 0, 4));
        emit(encS(1, 4, 8));
        emit(encI(7'h03, 6, 0, 108));
        emit(encR(7'h00, 3'b000, 7, 6, 5));
        runProgram("loadStore");

        startProgram();
        emit(encI(7'h13, 1, 0, 3));
        emit(encI(7'h13, 2, 0, 3));
        emit(encB(3'b000, 1, 2, 12));
        emit(encI(7'h13, 3, 0, 1));
        emit(encI(7'h13, 4, 0, 1));
        emit(encB(3'b001, 1, 2, 8));
        emit(encB(3'b000, 1, 0, 8));
        emit(encI(7'h13, 7, 0, 3));
        // Countdown loop on x7
        emit(encI(7'h13, 7, 7, -1));
        emit(encB(3'b001, 7, 0, -4));
        emit(encI(7'h13, 5, 7, 9));
        runProgram("branches");

        startProgram();
        emit(encI(7'h13, 0, 0, 55));
        emit(encI(7'h13, 1, 0, 1));
        emit(encR(7'h00, 3'b000, 0, 1, 1));
        emit(encR(7'h00, 3'b000, 2, 0, 1));
        emit(encI(7'h03, 0, 0, 0));
        emit(encR(7'h20, 3'b000, 3, 0, 2));
        runProgram("zeroReg");

        startProgram();
        buildRandom(300);
        runProgram("random");

        $display("Errors: %0d compare, %0d timeout", checkErrors, timeoutErrors);
        if (checkErrors == 0 && timeoutErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
source/isaPkg.sv
source/pipePkg.sv
source/fetchUnit.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/pipelineCore.sv
dv/coreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module coreTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log
